/* cpu_pkg.sv */
package cpu_pkg;

	// instruction fields
	localparam int OPC_LSB = 25;
	localparam int RT_LSB = 20;
	localparam int RA_LSB = 15;
	localparam int RB_LSB = 10;
	localparam int SUB_LSB = 0;
	localparam int BR_SEL_BIT = 14;
	localparam int BR_OFF_W = 14;
	localparam int JAL_SEL_BIT = 24;
	localparam int JAL_OFF_W = 24;

	localparam int LP_REG = 30;
	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	typedef enum logic [5:0] {
		LWI     = 6'b000010,
		SWI     = 6'b001010,
		TY_BASE = 6'b100000,
		MOVI    = 6'b100010,
		SETHI   = 6'b100011,
		TY_J    = 6'b100100,
		TY_B    = 6'b100110,
		ADDI    = 6'b101000,
		ANDI    = 6'b101010,
		XORI    = 6'b101011,
		ORI     = 6'b101100,
		SLTI    = 6'b101110
	} opcode_e;

	typedef enum logic [4:0] {
		ADD  = 5'b00000,
		SUB  = 5'b00001,
		AND  = 5'b00010,
		XOR  = 5'b00011,
		OR   = 5'b00100,
		SLT  = 5'b00110,
		SLTS = 5'b00111,
		SLLI = 5'b01000,
		SRLI = 5'b01001,
		SLL  = 5'b01100,
		SRL  = 5'b01101
	} sub_op_base_e;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLT  = 4'd5,
		ALU_SLTS = 4'd6,
		ALU_SLL  = 4'd7,
		ALU_SRL  = 4'd8
	} alu_op_e;

	typedef enum logic [1:0] {
		RB      = 2'd0,
		IMM     = 2'd1,
		UNKNOWN = 2'd2
	} alu_src2_e;

	typedef enum logic [2:0] {
		IMM_5BIT_ZE    = 3'd0,
		IMM_15BIT_SE   = 3'd1,
		IMM_15BIT_ZE   = 3'd2,
		IMM_20BIT_SE   = 3'd3,
		IMM_20BIT_HI   = 3'd4,
		IMM_15BIT_WORD = 3'd5,
		IMM_NONE       = 3'd6
	} imm_ext_e;

	typedef enum logic [1:0] {
		WR_ALU = 2'd0,
		WR_IMM = 2'd1,
		WR_MEM = 2'd2,
		WR_PC4 = 2'd3
	} wr_sel_e;

	typedef enum logic {
		RT = 1'b0,
		LP = 1'b1
	} wr_addr_e;

	typedef struct packed {
		alu_op_e   alu_op;
		alu_src2_e alu_src2;
		imm_ext_e  imm_ext;
		wr_sel_e   wr_sel;
		wr_addr_e  wr_addr;
		logic      dm_read;
		logic      dm_write;
		logic      reg_write;
		logic      branch;
		logic      jump;
		logic      take_branch;
	} ctrl_t;

	typedef enum logic [1:0] {
		FETCH   = 2'd0,
		EXECUTE = 2'd1,
		MEMORY  = 2'd2
	} seq_state_e;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [31:0] adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

endpackage

/* alu.sv */
`timescale 1ns/10ps

module alu (
	input  cpu_pkg::alu_op_e op,
	input  logic [31:0]      a,
	input  logic [31:0]      b,
	output logic [31:0]      result
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD: result = a + b;
			cpu_pkg::ALU_SUB: result = a - b;
			cpu_pkg::ALU_AND: result = a & b;
			cpu_pkg::ALU_OR: result = a | b;
			cpu_pkg::ALU_XOR: result = a ^ b;
			cpu_pkg::ALU_SLT: result = {31'b0, a < b};
			cpu_pkg::ALU_SLTS: result = {31'b0, $signed(a) < $signed(b)};
			cpu_pkg::ALU_SLL: result = a << shamt;
			cpu_pkg::ALU_SRL: result = a >> shamt;
			default: result = 32'h0;
		endcase
	end

endmodule

/* register_file.sv */
`timescale 1ns/10ps

module register_file (
	input  logic        clock,
	input  logic        reset,
	input  logic [4:0]  ra_addr,
	input  logic [4:0]  rb_addr,
	input  logic [4:0]  rt_addr,
	input  logic        write_en,
	input  logic [4:0]  write_addr,
	input  logic [31:0] write_data,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data,
	output logic [31:0] rt_data
);

	logic [31:0] regs [32];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'h0;
			end
		end else if (write_en) begin
			regs[write_addr] <= write_data;
		end
	end

	// reads are combinational
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

endmodule

/* controller.sv */
`timescale 1ns/10ps

module controller (
	input  logic [31:0]    instr,
	input  logic [31:0]    rt_data,
	input  logic [31:0]    ra_data,
	output cpu_pkg::ctrl_t ctrl
);

	cpu_pkg::opcode_e opcode;
	cpu_pkg::sub_op_base_e sub_op;
	logic rt_ra_equal;

	assign opcode = cpu_pkg::opcode_e'(instr[cpu_pkg::OPC_LSB +: 6]);
	assign sub_op = cpu_pkg::sub_op_base_e'(instr[cpu_pkg::SUB_LSB +: 5]);
	assign rt_ra_equal = (rt_data == ra_data);

	always_comb begin
		// no-op by default with all strobes low
		ctrl = '0;
		ctrl.alu_src2 = cpu_pkg::UNKNOWN;
		ctrl.imm_ext = cpu_pkg::IMM_NONE;
		case (opcode)
			cpu_pkg::TY_BASE: begin
				ctrl.alu_src2 = cpu_pkg::RB;
				ctrl.reg_write = 1'b1;
				case (sub_op)
					cpu_pkg::ADD: ctrl.alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::SUB: ctrl.alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::AND: ctrl.alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::OR: ctrl.alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::XOR: ctrl.alu_op = cpu_pkg::ALU_XOR;
					cpu_pkg::SLT: ctrl.alu_op = cpu_pkg::ALU_SLT;
					cpu_pkg::SLTS: ctrl.alu_op = cpu_pkg::ALU_SLTS;
					cpu_pkg::SLL: ctrl.alu_op = cpu_pkg::ALU_SLL;
					cpu_pkg::SRL: ctrl.alu_op = cpu_pkg::ALU_SRL;
					cpu_pkg::SLLI: begin
						ctrl.alu_op = cpu_pkg::ALU_SLL;
						ctrl.alu_src2 = cpu_pkg::IMM;
						ctrl.imm_ext = cpu_pkg::IMM_5BIT_ZE;
					end
					cpu_pkg::SRLI: begin
						ctrl.alu_op = cpu_pkg::ALU_SRL;
						ctrl.alu_src2 = cpu_pkg::IMM;
						ctrl.imm_ext = cpu_pkg::IMM_5BIT_ZE;
					end
					default: begin
						ctrl.alu_src2 = cpu_pkg::UNKNOWN;
						ctrl.reg_write = 1'b0;
					end
				endcase
			end
			cpu_pkg::ADDI, cpu_pkg::ANDI, cpu_pkg::ORI, cpu_pkg::XORI, cpu_pkg::SLTI: begin
				ctrl.alu_src2 = cpu_pkg::IMM;
				ctrl.reg_write = 1'b1;
				// logic ops take the immediate zero-extended
				ctrl.imm_ext = cpu_pkg::IMM_15BIT_ZE;
				case (opcode)
					cpu_pkg::ADDI: begin
						ctrl.alu_op = cpu_pkg::ALU_ADD;
						ctrl.imm_ext = cpu_pkg::IMM_15BIT_SE;
					end
					cpu_pkg::SLTI: begin
						ctrl.alu_op = cpu_pkg::ALU_SLT;
						ctrl.imm_ext = cpu_pkg::IMM_15BIT_SE;
					end
					cpu_pkg::ANDI: ctrl.alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::ORI: ctrl.alu_op = cpu_pkg::ALU_OR;
					default: ctrl.alu_op = cpu_pkg::ALU_XOR;
				endcase
			end
			cpu_pkg::MOVI, cpu_pkg::SETHI: begin
				ctrl.imm_ext = (opcode == cpu_pkg::MOVI) ? cpu_pkg::IMM_20BIT_SE
					: cpu_pkg::IMM_20BIT_HI;
				ctrl.wr_sel = cpu_pkg::WR_IMM;
				ctrl.reg_write = 1'b1;
			end
			cpu_pkg::LWI: begin
				ctrl.alu_src2 = cpu_pkg::IMM;
				ctrl.imm_ext = cpu_pkg::IMM_15BIT_WORD;
				ctrl.wr_sel = cpu_pkg::WR_MEM;
				ctrl.dm_read = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			cpu_pkg::SWI: begin
				ctrl.alu_src2 = cpu_pkg::IMM;
				ctrl.imm_ext = cpu_pkg::IMM_15BIT_WORD;
				ctrl.dm_write = 1'b1;
			end
			cpu_pkg::TY_B: begin
				ctrl.branch = 1'b1;
				// bit set selects bne
				ctrl.take_branch = instr[cpu_pkg::BR_SEL_BIT] ? !rt_ra_equal : rt_ra_equal;
			end
			cpu_pkg::TY_J: begin
				if (instr[cpu_pkg::JAL_SEL_BIT]) begin
					ctrl.jump = 1'b1;
					ctrl.wr_sel = cpu_pkg::WR_PC4;
					ctrl.wr_addr = cpu_pkg::LP;
					ctrl.reg_write = 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

/* datapath.sv */
`timescale 1ns/10ps

module datapath (
	input  logic           clock,
	input  logic           reset,
	input  logic [31:0]    instr,
	input  logic [31:0]    pc,
	input  cpu_pkg::ctrl_t ctrl,
	input  logic           wb_en,
	input  logic [31:0]    load_data,
	output logic [31:0]    rt_data,
	output logic [31:0]    ra_data,
	output logic [31:0]    alu_result,
	output logic [31:0]    store_data
);

	logic [31:0] rb_data;
	logic [31:0] imm;
	logic [31:0] br_offset;
	logic [31:0] jal_offset;
	logic [31:0] src_a;
	logic [31:0] src_b;
	logic [31:0] write_data;
	logic [4:0] write_addr;

	always_comb begin
		case (ctrl.imm_ext)
			cpu_pkg::IMM_5BIT_ZE: imm = {27'b0, instr[cpu_pkg::RB_LSB +: 5]};
			cpu_pkg::IMM_15BIT_SE: imm = {{17{instr[14]}}, instr[14:0]};
			cpu_pkg::IMM_15BIT_ZE: imm = {17'b0, instr[14:0]};
			cpu_pkg::IMM_20BIT_SE: imm = {{12{instr[19]}}, instr[19:0]};
			cpu_pkg::IMM_20BIT_HI: imm = {instr[19:0], 12'b0};
			cpu_pkg::IMM_15BIT_WORD: imm = {{15{instr[14]}}, instr[14:0], 2'b00};
			default: imm = 32'h0;
		endcase
	end

	// word offsets for branch and jal targets
	assign br_offset = {{(30 - cpu_pkg::BR_OFF_W){instr[cpu_pkg::BR_OFF_W - 1]}},
		instr[cpu_pkg::BR_OFF_W - 1:0], 2'b00};
	assign jal_offset = {{(30 - cpu_pkg::JAL_OFF_W){instr[cpu_pkg::JAL_OFF_W - 1]}},
		instr[cpu_pkg::JAL_OFF_W - 1:0], 2'b00};

	assign src_a = (ctrl.branch || ctrl.jump) ? pc : ra_data;
	assign src_b = ctrl.branch ? br_offset
		: ctrl.jump ? jal_offset
		: (ctrl.alu_src2 == cpu_pkg::IMM) ? imm : rb_data;

	always_comb begin
		case (ctrl.wr_sel)
			cpu_pkg::WR_IMM: write_data = imm;
			cpu_pkg::WR_MEM: write_data = load_data;
			cpu_pkg::WR_PC4: write_data = pc + 32'd4;
			default: write_data = alu_result;
		endcase
	end

	assign write_addr = (ctrl.wr_addr == cpu_pkg::LP) ? 5'(cpu_pkg::LP_REG)
		: instr[cpu_pkg::RT_LSB +: 5];
	assign store_data = rt_data;

	register_file u_register_file (
		.clock      (clock),
		.reset      (reset),
		.ra_addr    (instr[cpu_pkg::RA_LSB +: 5]),
		.rb_addr    (instr[cpu_pkg::RB_LSB +: 5]),
		.rt_addr    (instr[cpu_pkg::RT_LSB +: 5]),
		.write_en   (wb_en),
		.write_addr (write_addr),
		.write_data (write_data),
		.ra_data    (ra_data),
		.rb_data    (rb_data),
		.rt_data    (rt_data)
	);

	alu u_alu (
		.op     (ctrl.alu_op),
		.a      (src_a),
		.b      (src_b),
		.result (alu_result)
	);

endmodule

/* cpu_sequencer.sv */
`timescale 1ns/10ps

module cpu_sequencer (
	input  logic             clock,
	input  logic             reset,
	input  cpu_pkg::ctrl_t   ctrl,
	input  logic [31:0]      alu_result,
	input  logic [31:0]      store_data,
	output logic [31:0]      instr,
	output logic [31:0]      pc,
	output logic [31:0]      load_data,
	output logic             wb_en,
	output cpu_pkg::wb_req_t ibus_req,
	input  cpu_pkg::wb_rsp_t ibus_rsp,
	output cpu_pkg::wb_req_t dbus_req,
	input  cpu_pkg::wb_rsp_t dbus_rsp
);

	cpu_pkg::seq_state_e state;
	logic ibus_cyc;
	logic dbus_cyc;
	logic dbus_we;
	logic [31:0] dbus_adr;
	logic [31:0] dbus_dat;
	logic [31:0] pc_plus4;
	logic [31:0] next_pc;
	logic mem_op;

	assign pc_plus4 = pc + 32'd4;
	assign next_pc = (ctrl.take_branch || ctrl.jump) ? alu_result : pc_plus4;
	assign mem_op = ctrl.dm_read || ctrl.dm_write;

	// loads write back on the data ack, everything else in execute
	assign wb_en = ((state == cpu_pkg::EXECUTE) && ctrl.reg_write && !ctrl.dm_read) ||
		((state == cpu_pkg::MEMORY) && ctrl.dm_read && dbus_rsp.ack);
	assign load_data = dbus_rsp.dat;

	// pc stays put for the whole fetch, so it is the fetch address
	assign ibus_req = '{cyc: ibus_cyc, stb: ibus_cyc, we: 1'b0, adr: pc, dat: 32'h0};
	assign dbus_req = '{cyc: dbus_cyc, stb: dbus_cyc, we: dbus_we, adr: dbus_adr,
		dat: dbus_dat};

	always_ff @(posedge clock) begin
		if (state == cpu_pkg::FETCH && ibus_cyc && ibus_rsp.ack) begin
			instr <= ibus_rsp.dat;
		end
		if (state == cpu_pkg::EXECUTE && mem_op) begin
			dbus_adr <= alu_result;
			dbus_dat <= store_data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= cpu_pkg::FETCH;
			pc <= cpu_pkg::RESET_PC;
			ibus_cyc <= 1'b0;
			dbus_cyc <= 1'b0;
			dbus_we <= 1'b0;
		end else begin
			case (state)
				cpu_pkg::FETCH: begin
					if (!ibus_cyc) begin
						// only right after reset
						ibus_cyc <= 1'b1;
					end else if (ibus_rsp.ack) begin
						ibus_cyc <= 1'b0;
						state <= cpu_pkg::EXECUTE;
					end
				end
				cpu_pkg::EXECUTE: begin
					if (mem_op) begin
						dbus_cyc <= 1'b1;
						dbus_we <= ctrl.dm_write;
						state <= cpu_pkg::MEMORY;
					end else begin
						pc <= next_pc;
						ibus_cyc <= 1'b1;
						state <= cpu_pkg::FETCH;
					end
				end
				cpu_pkg::MEMORY: begin
					if (dbus_rsp.ack) begin
						dbus_cyc <= 1'b0;
						dbus_we <= 1'b0;
						pc <= pc_plus4;
						ibus_cyc <= 1'b1;
						state <= cpu_pkg::FETCH;
					end
				end
				default: state <= cpu_pkg::FETCH;
			endcase
		end
	end

endmodule

/* cpu_top.sv */
`timescale 1ns/10ps

module cpu_top (
	input  logic             clock,
	input  logic             reset,
	output cpu_pkg::wb_req_t ibus_req,
	input  cpu_pkg::wb_rsp_t ibus_rsp,
	output cpu_pkg::wb_req_t dbus_req,
	input  cpu_pkg::wb_rsp_t dbus_rsp
);

	cpu_pkg::ctrl_t ctrl;
	logic [31:0] instr;
	logic [31:0] pc;
	logic [31:0] load_data;
	logic [31:0] rt_data;
	logic [31:0] ra_data;
	logic [31:0] alu_result;
	logic [31:0] store_data;
	logic wb_en;

	cpu_sequencer u_cpu_sequencer (
		.clock      (clock),
		.reset      (reset),
		.ctrl       (ctrl),
		.alu_result (alu_result),
		.store_data (store_data),
		.instr      (instr),
		.pc         (pc),
		.load_data  (load_data),
		.wb_en      (wb_en),
		.ibus_req   (ibus_req),
		.ibus_rsp   (ibus_rsp),
		.dbus_req   (dbus_req),
		.dbus_rsp   (dbus_rsp)
	);

	controller u_controller (
		.instr   (instr),
		.rt_data (rt_data),
		.ra_data (ra_data),
		.ctrl    (ctrl)
	);

	datapath u_datapath (
		.clock      (clock),
		.reset      (reset),
		.instr      (instr),
		.pc         (pc),
		.ctrl       (ctrl),
		.wb_en      (wb_en),
		.load_data  (load_data),
		.rt_data    (rt_data),
		.ra_data    (ra_data),
		.alu_result (alu_result),
		.store_data (store_data)
	);

endmodule

/* cpu_checker.sv */
`timescale 1ns/10ps

module cpu_checker (
	input logic             clock,
	input logic             reset,
	input cpu_pkg::wb_req_t ibus_req,
	input cpu_pkg::wb_rsp_t ibus_rsp,
	input cpu_pkg::wb_req_t dbus_req,
	input cpu_pkg::wb_rsp_t dbus_rsp
);

	int fail_count = 0;

	a_ibus_stb_cyc: assert property (@(posedge clock) disable iff (reset)
		ibus_req.stb |-> ibus_req.cyc)
		else begin
			fail_count = fail_count + 1;
			$error("ibus stb high without cyc");
		end
	a_dbus_stb_cyc: assert property (@(posedge clock) disable iff (reset)
		dbus_req.stb |-> dbus_req.cyc)
		else begin
			fail_count = fail_count + 1;
			$error("dbus stb high without cyc");
		end

	a_ibus_ack_stb: assert property (@(posedge clock) disable iff (reset)
		ibus_rsp.ack |-> ibus_req.stb)
		else begin
			fail_count = fail_count + 1;
			$error("ibus ack without stb");
		end
	a_dbus_ack_stb: assert property (@(posedge clock) disable iff (reset)
		dbus_rsp.ack |-> dbus_req.stb)
		else begin
			fail_count = fail_count + 1;
			$error("dbus ack without stb");
		end

	// request held until acked
	a_ibus_stable: assert property (@(posedge clock) disable iff (reset)
		(ibus_req.stb && !ibus_rsp.ack) |=> (ibus_req.stb && $stable(ibus_req.adr) &&
		$stable(ibus_req.we) && $stable(ibus_req.dat)))
		else begin
			fail_count = fail_count + 1;
			$error("ibus request changed while waiting for ack");
		end
	a_dbus_stable: assert property (@(posedge clock) disable iff (reset)
		(dbus_req.stb && !dbus_rsp.ack) |=> (dbus_req.stb && $stable(dbus_req.adr) &&
		$stable(dbus_req.we) && $stable(dbus_req.dat)))
		else begin
			fail_count = fail_count + 1;
			$error("dbus request changed while waiting for ack");
		end

	a_one_bus: assert property (@(posedge clock) disable iff (reset)
		!(ibus_req.cyc && dbus_req.cyc))
		else begin
			fail_count = fail_count + 1;
			$error("both buses active at once");
		end

endmodule

/* cpu_monitor.sv */
`timescale 1ns/10ps

module cpu_monitor (
	input  logic             clock,
	input  logic             reset,
	input  cpu_pkg::wb_req_t dbus_req,
	input  cpu_pkg::wb_rsp_t dbus_rsp,
	input  logic [31:0]      exp_adr [64],
	input  logic [31:0]      exp_dat [64],
	input  int               exp_count,
	output logic             done,
	output int               test_count,
	output int               check_count,
	output int               error_count
);

	int idx;
	int test_errors;

	assign done = !reset && (exp_count > 0) && (idx >= exp_count);

	always @(posedge clock) begin
		if (reset) begin
			idx = 0;
			test_errors = 0;
			test_count = 0;
			check_count = 0;
			error_count = 0;
		end else if (dbus_req.stb && dbus_req.we && dbus_rsp.ack) begin
			if (idx >= exp_count) begin
				$display("unexpected store of 0x%08h to 0x%08h after the last expected store",
					dbus_req.dat, dbus_req.adr);
				error_count = error_count + 1;
			end else begin
				if (dbus_req.adr !== exp_adr[idx]) begin
					$display("** Error: dbus_req.adr = 0x%08h, expected 0x%08h",
						dbus_req.adr, exp_adr[idx]);
					test_errors = test_errors + 1;
				end
				if (dbus_req.dat !== exp_dat[idx]) begin
					$display("** Error: dbus_req.dat = 0x%08h, expected 0x%08h (adr 0x%08h)",
						dbus_req.dat, exp_dat[idx], exp_adr[idx]);
					test_errors = test_errors + 1;
				end
				check_count = check_count + 1;
				// store to 0x100 closes a test
				if (exp_adr[idx] == 32'h0000_0100) begin
					test_count = test_count + 1;
					if (test_errors == 0) begin
						$display("test %0d ok", exp_dat[idx]);
					end else begin
						$display("test %0d failed with %0d errors", exp_dat[idx], test_errors);
					end
					error_count = error_count + test_errors;
					test_errors = 0;
				end
				idx = idx + 1;
			end
		end
	end

endmodule

/* tb_cpu.sv */
`timescale 1ns/10ps

module tb_cpu;

	logic clock = 1'b0;
	logic reset = 1'b1;
	cpu_pkg::wb_req_t ibus_req;
	cpu_pkg::wb_rsp_t ibus_rsp = '0;
	cpu_pkg::wb_req_t dbus_req;
	cpu_pkg::wb_rsp_t dbus_rsp = '0;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] exp_adr [64];
	logic [31:0] exp_dat [64];
	int exp_count = 0;
	int prog_words = 0;
	logic [31:0] lcg_state = 32'h8bb9;
	int ibus_wait = -1;
	int dbus_wait = -1;
	logic loaded = 1'b0;
	logic finished = 1'b0;
	logic done;
	int test_count;
	int check_count;
	int error_count;

	always #5 clock = ~clock;

	cpu_top uut (
		.clock    (clock),
		.reset    (reset),
		.ibus_req (ibus_req),
		.ibus_rsp (ibus_rsp),
		.dbus_req (dbus_req),
		.dbus_rsp (dbus_rsp)
	);

	cpu_monitor u_monitor (
		.clock       (clock),
		.reset       (reset),
		.dbus_req    (dbus_req),
		.dbus_rsp    (dbus_rsp),
		.exp_adr     (exp_adr),
		.exp_dat     (exp_dat),
		.exp_count   (exp_count),
		.done        (done),
		.test_count  (test_count),
		.check_count (check_count),
		.error_count (error_count)
	);

	bind cpu_top cpu_checker u_checker (
		.clock    (clock),
		.reset    (reset),
		.ibus_req (ibus_req),
		.ibus_rsp (ibus_rsp),
		.dbus_req (dbus_req),
		.dbus_rsp (dbus_rsp)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// both slaves wait 0 to 3 cycles before each ack
	always @(negedge clock) begin
		if (reset) begin
			ibus_rsp <= '0;
			dbus_rsp <= '0;
			ibus_wait = -1;
			dbus_wait = -1;
		end else begin
			if (ibus_rsp.ack) begin
				ibus_rsp.ack <= 1'b0;
				ibus_wait = -1;
			end else if (ibus_req.stb) begin
				if (ibus_wait < 0) begin
					lcg_state = lcg_next(lcg_state);
					ibus_wait = int'(lcg_state[17:16]);
				end
				if (ibus_wait == 0) begin
					ibus_rsp <= '{ack: 1'b1, dat: imem[ibus_req.adr[9:2]]};
				end else begin
					ibus_wait = ibus_wait - 1;
				end
			end
			if (dbus_rsp.ack) begin
				dbus_rsp.ack <= 1'b0;
				dbus_wait = -1;
			end else if (dbus_req.stb) begin
				if (dbus_wait < 0) begin
					lcg_state = lcg_next(lcg_state);
					dbus_wait = int'(lcg_state[17:16]);
				end
				if (dbus_wait == 0) begin
					if (dbus_req.we) begin
						dmem[dbus_req.adr[9:2]] <= dbus_req.dat;
					end
					dbus_rsp <= '{ack: 1'b1, dat: dmem[dbus_req.adr[9:2]]};
				end else begin
					dbus_wait = dbus_wait - 1;
				end
			end
		end
	end

	task automatic load_program();
		int fd;
		int code;
		logic [7:0] tag;
		logic [31:0] a;
		logic [31:0] d;
		logic [2047:0] rest;
		fd = $fopen("program_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open program_input.txt");
			return;
		end
		code = $fscanf(fd, " %c", tag);
		while (code == 1) begin
			if (tag == "P") begin
				code = $fscanf(fd, "%h", d);
				imem[prog_words] = d;
				prog_words = prog_words + 1;
			end else if (tag == "E") begin
				code = $fscanf(fd, "%h %h", a, d);
				exp_adr[exp_count] = a;
				exp_dat[exp_count] = d;
				exp_count = exp_count + 1;
			end else begin
				code = $fgets(rest, fd);
			end
			code = $fscanf(fd, " %c", tag);
		end
		$fclose(fd);
	endtask

	initial begin
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0;
			dmem[i] = 32'h0;
		end
		for (int i = 0; i < 64; i++) begin
			exp_adr[i] = 32'h0;
			exp_dat[i] = 32'h0;
		end
		load_program();
		loaded = 1'b1;
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		wait (done);
		// room for any stray store
		repeat (20) @(posedge clock);
		finished = 1'b1;
		$display("tests: %0d, stores checked: %0d of %0d, errors: %0d, assertion failures: %0d",
			test_count, check_count, exp_count, error_count, uut.u_checker.fail_count);
		if (error_count == 0 && uut.u_checker.fail_count == 0 && exp_count > 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		wait (loaded);
		repeat (prog_words * 40 + 20) @(posedge clock);
		if (!finished) begin
			$display("timeout: %0d of %0d expected stores seen", check_count, exp_count);
			$display("FAIL: see errors above");
			$finish;
		end
	end

endmodule

/* program_input.txt */
# P <instruction word hex>, loaded from address 0
# E <store address hex> <store data hex>, in order; address 100 closes a test
# test 1 register alu ops
P 44100007
P 442ffffd
P 40308800
P 14300010
E 40 00000004
P 40308801
P 14300011
E 44 0000000a
P 40308802
P 14300012
E 48 00000005
P 40308804
P 14300013
E 4c ffffffff
P 40308803
P 14300014
E 50 fffffffa
P 40308806
P 14300015
E 54 00000001
P 40308807
P 14300016
E 58 00000000
P 4030840c
P 14300017
E 5c 00000380
P 4031040d
P 14300018
E 60 01ffffff
P 44a00001
P 14a00040
E 100 00000001
# test 2 immediate forms
P 5050fffb
P 14500020
E 80 00000002
P 5c50ffff
P 14500021
E 84 00000001
P 54517fff
P 14500022
E 88 00007ffd
P 58504000
P 14500023
E 8c 00004000
P 56514001
P 14500024
E 90 ffffbffc
P 40509008
P 14500025
E 94 00000070
P 40517009
P 14500026
E 98 0000000f
P 46412345
P 14400027
E 9c 12345000
P 44a00002
P 14a00040
E 100 00000002
# test 3 load after store, negative offsets from 0x200
P 44600200
P 44705a5a
P 14737ffe
E 1f8 00005a5a
P 04837ffe
P 50840001
P 14837fff
E 1fc 00005a5b
P 44a00003
P 14a00040
E 100 00000003
# test 4 beq taken, bne not taken, jal at 0xd0
P 4c108002
P 14100030
P 4c10c002
P 14100031
E c4 00000007
P 49000002
P 14100032
P 15e00033
E cc 000000d4
P 44a00004
P 14a00040
E 100 00000004
# test 5 undefined opcode and sub-opcode
P 44900033
P 14900034
E d0 00000033
P 7e900001
P 4090001f
P 14900035
E d4 00000033
P 44a00005
P 14a00040
E 100 00000005
# park
P 4c000000

/* all.f */
cpu_pkg.sv
alu.sv
register_file.sv
controller.sv
datapath.sv
cpu_sequencer.sv
cpu_top.sv
cpu_checker.sv
cpu_monitor.sv
tb_cpu.sv

/* run.sh */
#!/bin/sh
# build and run the cpu testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_cpu -o sim_tb_cpu
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
exit 0
